/* sim.f */
logic/lsu_pkg.sv
logic/axi_lite_if.sv
logic/lsu.sv
logic/axi_xbar.sv
logic/axi_sram.sv
logic/axi_uart.sv
logic/mem_subsys.sv
sim/tb_clock.sv
sim/mem_subsys_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module mem_subsys_tb -f sim.f -o mem_subsys_sim
out=$(./obj_dir/mem_subsys_sim) || true
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED"

/* sim/mem_subsys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_read  = 2'd1,
        op_write = 2'd2
    } op_t;

    typedef struct packed {
        op_t            op;
        lsu_pkg::size_t size;
        logic           sign;
        logic [31:0]    addr;
        logic [31:0]    wdata;
        logic [31:0]    exp_rdata;
        logic           exp_tx;
        logic [7:0]     exp_tx_byte;
    } row_t;

    logic           clk;
    logic           reset;
    logic           start;
    logic           wen;
    logic           ren;
    logic           sign;
    lsu_pkg::size_t size;
    logic [31:0]    addr;
    logic [31:0]    wdata;
    logic [31:0]    rdata;
    logic           done;
    logic [7:0]     tx_data;
    logic           tx_valid;

    row_t        rows[$];
    logic [31:0] shadow [256]; // expected sram contents
    logic [31:0] lfsr;
    logic        table_ready;
    logic        done_q;
    int          tx_count;

    tb_clock #(.period_ns(8)) u_clock (.clk(clk));

    mem_subsys u_dut (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .wen      (wen),
        .ren      (ren),
        .sign     (sign),
        .size     (size),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .done     (done),
        .tx_data  (tx_data),
        .tx_valid (tx_valid)
    );

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_size(input string name, input lsu_pkg::size_t got,
                              input lsu_pkg::size_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = 32'h0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // appends a row and works out its expected results from the shadow memory
    task automatic add_row(input op_t op, input lsu_pkg::size_t sz, input logic sgn,
                           input logic [31:0] a, input logic [31:0] d);
        row_t        r;
        logic [31:0] word;
        logic [1:0]  off;
        logic [7:0]  b;
        logic [15:0] h;
        off           = a[1:0];
        word          = shadow[a[9:2]];
        r.op          = op;
        r.size        = sz;
        r.sign        = sgn;
        r.addr        = a;
        r.wdata       = d;
        r.exp_rdata   = 32'h0; // uart reads as zero
        r.exp_tx      = 1'b0;
        r.exp_tx_byte = d[7:0];
        if (a == lsu_pkg::uart_addr) begin
            r.exp_tx = (op == op_write) && (sz != lsu_pkg::size_none);
        end else if (op == op_write) begin
            case (sz)
                lsu_pkg::size_byte: word[{off, 3'b000} +: 8]     = d[7:0];
                lsu_pkg::size_half: word[{off[1], 4'b0000} +: 16] = d[15:0];
                lsu_pkg::size_word: word = d;
                default: ;
            endcase
            shadow[a[9:2]] = word;
        end else if (op == op_read) begin
            b = word[{off, 3'b000} +: 8];
            h = word[{off[1], 4'b0000} +: 16];
            case (sz)
                lsu_pkg::size_byte: r.exp_rdata = (sgn && b[7]) ? {24'hffffff, b} : {24'h0, b};
                lsu_pkg::size_half: r.exp_rdata = (sgn && h[15]) ? {16'hffff, h} : {16'h0, h};
                default:            r.exp_rdata = word;
            endcase
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] off;
        // word round trips
        add_row(op_write, lsu_pkg::size_word, 1'b0, 32'h000, rand_bits(32));
        add_row(op_write, lsu_pkg::size_word, 1'b0, 32'h004, rand_bits(32));
        add_row(op_write, lsu_pkg::size_word, 1'b0, 32'h040, rand_bits(32));
        add_row(op_write, lsu_pkg::size_word, 1'b0, 32'h1fc, rand_bits(32));
        add_row(op_write, lsu_pkg::size_word, 1'b0, 32'h3f8, rand_bits(32)); // uart alias
        add_row(op_write, lsu_pkg::size_word, 1'b0, 32'h100, 32'h8c7e91f0);
        add_row(op_read, lsu_pkg::size_word, 1'b0, 32'h000, 32'h0);
        add_row(op_read, lsu_pkg::size_word, 1'b0, 32'h004, 32'h0);
        add_row(op_read, lsu_pkg::size_word, 1'b0, 32'h040, 32'h0);
        add_row(op_read, lsu_pkg::size_word, 1'b0, 32'h1fc, 32'h0);
        // partial stores keep the other lanes
        add_row(op_write, lsu_pkg::size_byte, 1'b0, 32'h041, rand_bits(32));
        add_row(op_write, lsu_pkg::size_half, 1'b0, 32'h006, rand_bits(32));
        add_row(op_write, lsu_pkg::size_byte, 1'b0, 32'h003, rand_bits(32));
        add_row(op_write, lsu_pkg::size_half, 1'b0, 32'h1fc, rand_bits(32));
        add_row(op_read, lsu_pkg::size_word, 1'b0, 32'h040, 32'h0);
        add_row(op_read, lsu_pkg::size_word, 1'b0, 32'h004, 32'h0);
        add_row(op_read, lsu_pkg::size_word, 1'b0, 32'h000, 32'h0);
        add_row(op_read, lsu_pkg::size_word, 1'b0, 32'h1fc, 32'h0);
        for (int s = 0; s < 2; s++) begin
            for (int o = 0; o < 4; o++) begin
                add_row(op_read, lsu_pkg::size_byte, s[0], 32'h100 + o, 32'h0);
                if (!o[0])
                    add_row(op_read, lsu_pkg::size_half, s[0], 32'h100 + o, 32'h0);
            end
        end
        // serial register
        add_row(op_write, lsu_pkg::size_byte, 1'b0, lsu_pkg::uart_addr, rand_bits(32));
        add_row(op_read, lsu_pkg::size_word, 1'b0, 32'h3f8, 32'h0);
        add_row(op_write, lsu_pkg::size_word, 1'b0, lsu_pkg::uart_addr, rand_bits(32));
        add_row(op_read, lsu_pkg::size_word, 1'b0, lsu_pkg::uart_addr, 32'h0);
        add_row(op_read, lsu_pkg::size_byte, 1'b1, lsu_pkg::uart_addr, 32'h0);
        add_row(op_read, lsu_pkg::size_word, 1'b0, 32'h3f8, 32'h0);
        // no access at all
        add_row(op_none, lsu_pkg::size_word, 1'b0, 32'h000, rand_bits(32));
        add_row(op_write, lsu_pkg::size_none, 1'b0, 32'h000, rand_bits(32));
        add_row(op_read, lsu_pkg::size_word, 1'b0, 32'h000, 32'h0);
        for (int i = 0; i < 8; i++) begin
            a   = 32'h80 + (rand_bits(4) << 2); // 0x80 to 0xbc
            off = rand_bits(2);
            add_row(op_write, lsu_pkg::size_word, 1'b0, a, rand_bits(32));
            add_row(op_write, lsu_pkg::size_byte, 1'b0, a + off, rand_bits(32));
            add_row(op_read, lsu_pkg::size_byte, i[0], a + off, 32'h0);
            add_row(op_read, lsu_pkg::size_word, 1'b0, a, 32'h0);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            done_q   <= 1'b0;
            tx_count <= 0;
        end else begin
            done_q <= done;
            if (done && done_q) begin
                $display("done stayed high for two cycles in a row");
                stop_run();
            end
            if (tx_valid)
                tx_count <= tx_count + 1;
        end
    end

    initial begin
        wait (table_ready);
        repeat ((rows.size() + 1) * 64 + 16) @(posedge clk);
        $display("timeout: an access did not finish in time");
        stop_run();
    end

    initial begin
        row_t r;
        int   tx_before;
        reset       = 1'b1;
        start       = 1'b0;
        wen         = 1'b0;
        ren         = 1'b0;
        sign        = 1'b0;
        size        = lsu_pkg::size_none;
        addr        = 32'h0;
        wdata       = 32'h0;
        table_ready = 1'b0;
        lfsr        = 32'hfe0f0ba5;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            @(posedge clk);
            #1;
            tx_before = tx_count;
            start     = 1'b1;
            wen       = (r.op == op_write);
            ren       = (r.op == op_read);
            sign      = r.sign;
            size      = r.size;
            addr      = r.addr;
            wdata     = r.wdata;
            @(posedge clk);
            #1;
            start = 1'b0;
            wen   = 1'b0;
            ren   = 1'b0;
            while (!done) begin
                @(posedge clk);
                #1;
            end
            check_size("req_size", u_dut.u_lsu.req_size, r.size);
            if (r.op == op_read)
                check_word("rdata", rdata, r.exp_rdata);
            if (r.exp_tx)
                check_byte("tx_data", tx_data, r.exp_tx_byte);
            check_word("tx_valid pulses", tx_count - tx_before, {31'h0, r.exp_tx});
        end
        repeat (4) @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* logic/mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           wen,
    input  logic           ren,
    input  logic           sign,
    input  lsu_pkg::size_t size,
    input  logic [31:0]    addr,
    input  logic [31:0]    wdata,
    output logic [31:0]    rdata,
    output logic           done,
    output logic [7:0]     tx_data,
    output logic           tx_valid
);

    axi_lite_if bus_m ();
    axi_lite_if bus_sram ();
    axi_lite_if bus_uart ();

    lsu u_lsu (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .wen   (wen),
        .ren   (ren),
        .sign  (sign),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .bus   (bus_m)
    );

    axi_xbar u_xbar (
        .m      (bus_m),
        .s_sram (bus_sram),
        .s_uart (bus_uart)
    );

    axi_sram u_sram (
        .clk   (clk),
        .reset (reset),
        .bus   (bus_sram)
    );

    axi_uart u_uart (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus_uart),
        .tx_data  (tx_data),
        .tx_valid (tx_valid)
    );

endmodule

`default_nettype wire

/* logic/axi_uart.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_uart (
    input  logic       clk,
    input  logic       reset,
    axi_lite_if.slave  bus,
    output logic [7:0] tx_data,
    output logic       tx_valid
);

    logic       aw_done;
    logic [7:0] tx_byte;

    assign bus.rdata = '0; // tx register reads as zero
    assign bus.rresp = lsu_pkg::resp_okay;
    assign bus.bresp = lsu_pkg::resp_okay;

    // lowest strobed lane wins
    always_comb begin
        if (bus.wstrb[0])      tx_byte = bus.wdata[7:0];
        else if (bus.wstrb[1]) tx_byte = bus.wdata[15:8];
        else if (bus.wstrb[2]) tx_byte = bus.wdata[23:16];
        else                   tx_byte = bus.wdata[31:24];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.arready <= 1'b0;
            bus.rvalid  <= 1'b0;
            bus.awready <= 1'b0;
            bus.wready  <= 1'b0;
            bus.bvalid  <= 1'b0;
            aw_done     <= 1'b0;
            tx_valid    <= 1'b0;
        end else begin
            tx_valid <= 1'b0;
            if (bus.arvalid && !bus.arready && !bus.rvalid) bus.arready <= 1'b1;
            if (bus.arvalid && bus.arready) begin
                bus.arready <= 1'b0;
                bus.rvalid  <= 1'b1;
            end
            if (bus.rvalid && bus.rready) bus.rvalid <= 1'b0;

            if (bus.awvalid && !bus.awready && !aw_done && !bus.bvalid) bus.awready <= 1'b1;
            if (bus.awvalid && bus.awready) begin
                bus.awready <= 1'b0;
                aw_done     <= 1'b1;
            end
            if (bus.wvalid && !bus.wready && aw_done) bus.wready <= 1'b1;
            if (bus.wvalid && bus.wready) begin
                bus.wready <= 1'b0;
                aw_done    <= 1'b0;
                bus.bvalid <= 1'b1;
                tx_valid   <= 1'b1; // one pulse per byte
            end
            if (bus.bvalid && bus.bready) bus.bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.wvalid && bus.wready)
            tx_data <= tx_byte;
    end

    a_strb_set: assert property (@(posedge clk) disable iff (reset)
        bus.wvalid |-> bus.wstrb != '0);

endmodule

`default_nettype wire

/* logic/axi_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_sram (
    input  logic       clk,
    input  logic       reset,
    axi_lite_if.slave  bus
);

    logic [lsu_pkg::data_w-1:0] mem [lsu_pkg::sram_words];
    logic [lsu_pkg::data_w-1:0] rdata_q;
    logic [7:0]                 widx;
    logic                       aw_done;

    assign bus.rdata = rdata_q;
    assign bus.rresp = lsu_pkg::resp_okay;
    assign bus.bresp = lsu_pkg::resp_okay;

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.arready <= 1'b0;
            bus.rvalid  <= 1'b0;
            bus.awready <= 1'b0;
            bus.wready  <= 1'b0;
            bus.bvalid  <= 1'b0;
            aw_done     <= 1'b0;
        end else begin
            // read side
            if (bus.arvalid && !bus.arready && !bus.rvalid)
                bus.arready <= 1'b1;
            if (bus.arvalid && bus.arready) begin
                bus.arready <= 1'b0;
                bus.rvalid  <= 1'b1;
            end
            if (bus.rvalid && bus.rready)
                bus.rvalid <= 1'b0;

            // write side
            if (bus.awvalid && !bus.awready && !aw_done && !bus.bvalid)
                bus.awready <= 1'b1;
            if (bus.awvalid && bus.awready) begin
                bus.awready <= 1'b0;
                aw_done     <= 1'b1;
            end
            if (bus.wvalid && !bus.wready && aw_done)
                bus.wready <= 1'b1;
            if (bus.wvalid && bus.wready) begin
                bus.wready <= 1'b0;
                aw_done    <= 1'b0;
                bus.bvalid <= 1'b1;
            end
            if (bus.bvalid && bus.bready)
                bus.bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.arvalid && bus.arready)
            rdata_q <= mem[bus.araddr[9:2]];
        if (bus.awvalid && bus.awready)
            widx <= bus.awaddr[9:2];
        if (bus.wvalid && bus.wready) begin
            for (int i = 0; i < lsu_pkg::strb_w; i++) begin
                if (bus.wstrb[i])
                    mem[widx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/axi_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_xbar (
    axi_lite_if.slave  m,
    axi_lite_if.master s_sram,
    axi_lite_if.master s_uart
);

    lsu_pkg::dev_sel_t          sel;
    logic [lsu_pkg::addr_w-1:0] dec_addr;
    logic                       to_sram;
    logic                       to_uart;

    always_comb begin
        dec_addr = m.arvalid ? m.araddr : m.awaddr;
        sel      = (dec_addr == lsu_pkg::uart_addr) ? lsu_pkg::dev_uart : lsu_pkg::dev_sram;
    end

    assign to_sram = (sel == lsu_pkg::dev_sram);
    assign to_uart = (sel == lsu_pkg::dev_uart);

    // payloads go to both devices
    assign s_sram.araddr = m.araddr;
    assign s_sram.awaddr = m.awaddr;
    assign s_sram.wdata  = m.wdata;
    assign s_sram.wstrb  = m.wstrb;
    assign s_uart.araddr = m.araddr;
    assign s_uart.awaddr = m.awaddr;
    assign s_uart.wdata  = m.wdata;
    assign s_uart.wstrb  = m.wstrb;

    assign s_sram.arvalid = m.arvalid & to_sram;
    assign s_sram.awvalid = m.awvalid & to_sram;
    assign s_sram.wvalid  = m.wvalid  & to_sram;
    assign s_sram.rready  = m.rready  & to_sram;
    assign s_sram.bready  = m.bready  & to_sram;
    assign s_uart.arvalid = m.arvalid & to_uart;
    assign s_uart.awvalid = m.awvalid & to_uart;
    assign s_uart.wvalid  = m.wvalid  & to_uart;
    assign s_uart.rready  = m.rready  & to_uart;
    assign s_uart.bready  = m.bready  & to_uart;

    assign m.arready = to_uart ? s_uart.arready : s_sram.arready;
    assign m.rdata   = to_uart ? s_uart.rdata   : s_sram.rdata;
    assign m.rresp   = to_uart ? s_uart.rresp   : s_sram.rresp;
    assign m.rvalid  = to_uart ? s_uart.rvalid  : s_sram.rvalid;
    assign m.awready = to_uart ? s_uart.awready : s_sram.awready;
    assign m.wready  = to_uart ? s_uart.wready  : s_sram.wready;
    assign m.bresp   = to_uart ? s_uart.bresp   : s_sram.bresp;
    assign m.bvalid  = to_uart ? s_uart.bvalid  : s_sram.bvalid;

    // a device valid only where its own channel address selects that device
    always_comb begin
        assert (s_uart.arvalid !== 1'b1 || m.araddr == lsu_pkg::uart_addr);
        assert ((s_uart.awvalid | s_uart.wvalid) !== 1'b1 || m.awaddr == lsu_pkg::uart_addr);
        assert (s_sram.arvalid !== 1'b1 || m.araddr != lsu_pkg::uart_addr);
        assert ((s_sram.awvalid | s_sram.wvalid) !== 1'b1 || m.awaddr != lsu_pkg::uart_addr);
    end

endmodule

`default_nettype wire

/* logic/lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                wen,
    input  logic                ren,
    input  logic                sign,
    input  lsu_pkg::size_t      size,
    input  logic [31:0]         addr,
    input  logic [31:0]         wdata,
    output logic [31:0]         rdata,
    output logic                done,
    axi_lite_if.master          bus
);

    typedef enum logic [2:0] {
        st_idle,
        st_ar,
        st_r,
        st_aw,
        st_w,
        st_b
    } state_t;

    state_t state;

    logic                        access;
    logic                        req_sign;
    lsu_pkg::size_t              req_size;
    logic [31:0]                 req_addr;
    logic [31:0]                 req_wdata;
    logic [31:0]                 rword;
    logic [31:0]                 rshift;
    logic [1:0]                  off;
    logic [lsu_pkg::strb_w-1:0]  strb;

    // size_none behaves like no access at all
    assign access = (ren | wen) && (size != lsu_pkg::size_none);
    assign off    = req_addr[1:0];

    always_ff @(posedge clk) begin
        if (start && state == st_idle) begin
            req_sign  <= sign;
            req_size  <= size;
            req_addr  <= addr;
            req_wdata <= wdata;
        end
        if (state == st_r && bus.rvalid && bus.rready)
            rword <= bus.rdata;
    end

    always_comb begin
        case (req_size)
            lsu_pkg::size_byte: strb = 4'b0001 << off;
            lsu_pkg::size_half: strb = off[1] ? 4'b1100 : 4'b0011;
            lsu_pkg::size_word: strb = 4'b1111;
            default:            strb = 4'b0000;
        endcase
    end

    // both addresses held for the whole access, xbar decodes from either
    assign bus.araddr = req_addr;
    assign bus.awaddr = req_addr;
    assign bus.wdata  = req_wdata << {off, 3'b000};
    assign bus.wstrb  = strb;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_idle;
            bus.arvalid <= 1'b0;
            bus.rready  <= 1'b0;
            bus.awvalid <= 1'b0;
            bus.wvalid  <= 1'b0;
            bus.bready  <= 1'b0;
            done        <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        if (!access) begin
                            done <= 1'b1;
                        end else if (ren) begin
                            bus.arvalid <= 1'b1;
                            state       <= st_ar;
                        end else begin
                            bus.awvalid <= 1'b1;
                            state       <= st_aw;
                        end
                    end
                end
                st_ar: begin
                    if (bus.arready) begin
                        bus.arvalid <= 1'b0;
                        state       <= st_r;
                    end
                end
                st_r: begin
                    if (bus.rvalid && !bus.rready) bus.rready <= 1'b1; // one cycle late
                    if (bus.rvalid && bus.rready) begin
                        bus.rready <= 1'b0;
                        done       <= 1'b1;
                        state      <= st_idle;
                    end
                end
                st_aw: begin
                    if (bus.awready) begin
                        bus.awvalid <= 1'b0;
                        bus.wvalid  <= 1'b1; // W only after AW
                        state       <= st_w;
                    end
                end
                st_w: begin
                    if (bus.wready) begin
                        bus.wvalid <= 1'b0;
                        state      <= st_b;
                    end
                end
                st_b: begin
                    if (bus.bvalid && !bus.bready) bus.bready <= 1'b1;
                    if (bus.bvalid && bus.bready) begin
                        bus.bready <= 1'b0;
                        done       <= 1'b1;
                        state      <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign rshift = rword >> {off, 3'b000};

    always_comb begin
        case (req_size)
            lsu_pkg::size_byte: rdata = {{24{rshift[7] & req_sign}}, rshift[7:0]};
            lsu_pkg::size_half: rdata = {{16{rshift[15] & req_sign}}, rshift[15:0]};
            lsu_pkg::size_word: rdata = rshift;
            default:            rdata = 32'h0;
        endcase
    end

    a_half_aligned: assert property (@(posedge clk) disable iff (reset)
        start && (ren || wen) && size == lsu_pkg::size_half |-> !addr[0]);

    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        start && (ren || wen) && size == lsu_pkg::size_word |-> addr[1:0] == 2'b00);

    a_one_dir: assert property (@(posedge clk) disable iff (reset) start |-> !(wen && ren));

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done);

endmodule

`default_nettype wire

/* logic/axi_lite_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface axi_lite_if;

    logic [lsu_pkg::addr_w-1:0] araddr;
    logic                       arvalid;
    logic                       arready;

    logic [lsu_pkg::data_w-1:0] rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
    logic                       rready;

    logic [lsu_pkg::addr_w-1:0] awaddr;
    logic                       awvalid;
    logic                       awready;

    logic [lsu_pkg::data_w-1:0] wdata;
    logic [lsu_pkg::strb_w-1:0] wstrb;
    logic                       wvalid;
    logic                       wready;

    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       bready;

    modport master (
        output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

    modport slave (
        input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

endinterface

`default_nettype wire

/* logic/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    localparam logic [addr_w-1:0] uart_addr = 32'ha00003f8; // serial tx register

    // sram is indexed by addr[9:2], upper bits alias
    localparam int sram_words = 256;

    // same encoding as the core's mem mask field
    typedef enum logic [1:0] {
        size_none = 2'b00,
        size_byte = 2'b01,
        size_half = 2'b10,
        size_word = 2'b11
    } size_t;

    localparam logic [1:0] resp_okay = 2'b00;

    typedef enum logic {
        dev_sram = 1'b0,
        dev_uart = 1'b1
    } dev_sel_t;

endpackage

`default_nettype wire
